/* rtl/rom_pkg.sv */
//////////////////////////////
// ROM path package
// Address widths, download header
// layout and client payload types
//////////////////////////////

`default_nettype none

package rom_pkg;

    // SDRAM bank word address
    localparam int ADDR_W = 22;

    // Download header bytes ahead of ROM data
    localparam int HEADER_LEN = 2;
    localparam int CFG_AW = $clog2(HEADER_LEN);

    // Graphics region start is given in 64-word units
    localparam int GFX_SHIFT = 6;

    // Read clients: 0 is main CPU, 1 is graphics
    localparam int N_CLIENTS = 2;
    localparam int CLIENT_W = $clog2(N_CLIENTS);

    typedef logic [CFG_AW-1:0] cfg_addr_t;
    typedef logic [15:0]       gfx_start_t;

    typedef logic [19:0]       main_addr_t;
    typedef logic [19:0]       gfx_addr_t;
    typedef logic [15:0]       main_data_t;
    typedef logic [31:0]       gfx_data_t;

endpackage

`default_nettype wire

/* rtl/rom_loader.sv */
//////////////////////////////
// ROM download loader
// Packs ioctl bytes into 16-bit
// SDRAM words, sends header bytes
// to the region configuration
//////////////////////////////

`default_nettype none

module rom_loader import rom_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic [24:0]       ioctl_addr,
    input  logic [7:0]        ioctl_data,
    input  logic              ioctl_wr,
    input  logic              downloading,
    input  logic              prog_rdy,
    output logic [ADDR_W-1:0] prog_addr,
    output logic [15:0]       prog_data,
    output logic [1:0]        prog_mask,
    output logic              prog_we,
    output logic              dwnld_busy,
    output logic              cfg_we,
    output cfg_addr_t         cfg_addr,
    output logic [7:0]        cfg_data
);

    logic [24:0] rom_addr;
    logic        is_header;
    logic        rom_wr;
    logic [7:0]  low_byte;

    assign is_header = ioctl_addr < 25'(HEADER_LEN);
    assign rom_addr  = ioctl_addr - 25'(HEADER_LEN);
    assign rom_wr    = ioctl_wr && !is_header;

    // Both bytes always written
    assign prog_mask = 2'b00;

    assign dwnld_busy = downloading | prog_we;

    // Header bytes become one-cycle config writes
    always_ff @(posedge clk) begin
        if (rst) begin
            cfg_we <= 1'b0;
        end else begin
            cfg_we <= ioctl_wr && is_header;
        end
    end

    always_ff @(posedge clk) begin
        if (ioctl_wr && is_header) begin
            cfg_addr <= ioctl_addr[CFG_AW-1:0];
            cfg_data <= ioctl_data;
        end
    end

    // Even byte waits for its odd partner
    always_ff @(posedge clk) begin
        if (rom_wr && !rom_addr[0]) begin
            low_byte <= ioctl_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rom_wr && rom_addr[0]) begin
            prog_addr <= rom_addr[ADDR_W:1];
            prog_data <= {ioctl_data, low_byte};
        end
    end

    // Held until the SDRAM confirms the write
    always_ff @(posedge clk) begin
        if (rst) begin
            prog_we <= 1'b0;
        end else if (rom_wr && rom_addr[0]) begin
            prog_we <= 1'b1;
        end else if (prog_rdy) begin
            prog_we <= 1'b0;
        end
    end

endmodule

`default_nettype wire

/* rtl/region_cfg.sv */
//////////////////////////////
// Region configuration
// Byte registers loaded from the
// download header, giving the
// graphics region start
//////////////////////////////

`default_nettype none

module region_cfg import rom_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  logic       cfg_we,
    input  cfg_addr_t  cfg_addr,
    input  logic [7:0] cfg_data,
    output gfx_start_t gfx_start
);

    logic [7:0] regs [HEADER_LEN];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < HEADER_LEN; i++) begin
                regs[i] <= 8'd0;
            end
        end else if (cfg_we) begin
            regs[cfg_addr] <= cfg_data;
        end
    end

    // Byte 0 is the low byte
    genvar b;
    generate
        for (b = 0; b < HEADER_LEN; b++) begin : g_byte
            assign gfx_start[8*b +: 8] = regs[b];
        end
    endgenerate

endmodule

`default_nettype wire

/* rtl/rom_slot.sv */
//////////////////////////////
// ROM fetch slot
// One-entry cache between a ROM
// client and the bank arbiter
//////////////////////////////

`default_nettype none

module rom_slot import rom_pkg::*; #(
    parameter type addr_t = main_addr_t,
    parameter type data_t = main_data_t
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              cs,
    input  addr_t             addr,
    input  logic [ADDR_W-1:0] offset,
    input  logic              flush,
    input  logic              done,
    input  logic [31:0]       data_read,
    output logic              ok,
    output data_t             data,
    output logic              req,
    output logic [ADDR_W-1:0] req_addr
);

    localparam int DATA_W = $bits(data_t);

    addr_t cached_addr;
    logic  valid;
    logic  hit;

    assign hit = valid && (cached_addr == addr);

    // Client holds addr steady while waiting
    assign req_addr = offset + ADDR_W'(addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
            req   <= 1'b0;
            ok    <= 1'b0;
        end else begin
            ok <= cs && !flush && (hit || done);
            if (done) begin
                req   <= 1'b0;
                valid <= !flush;
            end else if (flush) begin
                valid <= 1'b0;
            end else if (cs && !hit && !req) begin
                req <= 1'b1;
            end
        end
    end

    // Refill on the arbiter strobe
    always_ff @(posedge clk) begin
        if (done) begin
            cached_addr <= addr;
            data        <= data_read[DATA_W-1:0];
        end
    end

endmodule

`default_nettype wire

/* rtl/bank_arbiter.sv */
//////////////////////////////
// SDRAM bank arbiter
// Round-robin read access to one
// bank for the cache slots
//////////////////////////////

`default_nettype none

module bank_arbiter import rom_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic [N_CLIENTS-1:0] req,
    input  logic [ADDR_W-1:0]    req_addr [N_CLIENTS],
    input  logic                 ba_ack,
    input  logic                 ba_rdy,
    input  logic                 busy,
    output logic [N_CLIENTS-1:0] done,
    output logic [ADDR_W-1:0]    ba_addr,
    output logic                 ba_rd
);

    logic                active;
    logic [CLIENT_W-1:0] sel;
    logic [CLIENT_W-1:0] prio;
    logic [CLIENT_W-1:0] pick;
    logic                found;

    // First requester at or after the priority pointer
    always_comb begin
        found = 1'b0;
        pick  = prio;
        for (int i = 0; i < N_CLIENTS; i++) begin
            if (!found && req[(int'(prio) + i) % N_CLIENTS]) begin
                found = 1'b1;
                pick  = CLIENT_W'((int'(prio) + i) % N_CLIENTS);
            end
        end
    end

    // Data is on data_read only while ba_rdy is up
    always_comb begin
        done = '0;
        if (active && ba_rdy) begin
            done[sel] = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            ba_rd  <= 1'b0;
            prio   <= '0;
        end else if (!active) begin
            if (found && !busy) begin
                active <= 1'b1;
                ba_rd  <= 1'b1;
            end
        end else begin
            if (ba_ack) begin
                ba_rd <= 1'b0;
            end
            if (ba_rdy) begin
                active <= 1'b0;
                prio   <= CLIENT_W'((int'(sel) + 1) % N_CLIENTS);
            end
        end
    end

    // Grant and address latched together
    always_ff @(posedge clk) begin
        if (!active && found && !busy) begin
            sel     <= pick;
            ba_addr <= req_addr[pick];
        end
    end

endmodule

`default_nettype wire

/* rtl/rom_game.sv */
//////////////////////////////
// ROM game top level
// Download and fetch paths that
// share one SDRAM bank
//////////////////////////////

`default_nettype none

module rom_game import rom_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    // ROM download
    input  logic [24:0]       ioctl_addr,
    input  logic [7:0]        ioctl_data,
    input  logic              ioctl_wr,
    input  logic              downloading,
    output logic              dwnld_busy,
    // SDRAM programming
    output logic [ADDR_W-1:0] prog_addr,
    output logic [15:0]       prog_data,
    output logic [1:0]        prog_mask,
    output logic              prog_we,
    input  logic              prog_rdy,
    // Bank read port
    output logic [ADDR_W-1:0] ba_addr,
    output logic              ba_rd,
    input  logic              ba_ack,
    input  logic              ba_rdy,
    input  logic [31:0]       data_read,
    // Main CPU ROM
    input  logic              main_rom_cs,
    input  main_addr_t        main_rom_addr,
    output logic              main_rom_ok,
    output main_data_t        main_rom_data,
    // Graphics ROM
    input  logic              gfx_rom_cs,
    input  gfx_addr_t         gfx_rom_addr,
    output logic              gfx_rom_ok,
    output gfx_data_t         gfx_rom_data
);

    logic                 cfg_we;
    cfg_addr_t            cfg_addr;
    logic [7:0]           cfg_data;
    gfx_start_t           gfx_start;
    logic [ADDR_W-1:0]    gfx_offset;
    logic [N_CLIENTS-1:0] req;
    logic [N_CLIENTS-1:0] done;
    logic [ADDR_W-1:0]    req_addr [N_CLIENTS];

    assign gfx_offset = ADDR_W'(gfx_start) << GFX_SHIFT;

    rom_loader u_loader(
        .clk         ( clk         ),
        .rst         ( rst         ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .downloading ( downloading ),
        .prog_rdy    ( prog_rdy    ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .dwnld_busy  ( dwnld_busy  ),
        .cfg_we      ( cfg_we      ),
        .cfg_addr    ( cfg_addr    ),
        .cfg_data    ( cfg_data    )
    );

    region_cfg u_cfg(
        .clk       ( clk       ),
        .rst       ( rst       ),
        .cfg_we    ( cfg_we    ),
        .cfg_addr  ( cfg_addr  ),
        .cfg_data  ( cfg_data  ),
        .gfx_start ( gfx_start )
    );

    rom_slot #(.addr_t(main_addr_t), .data_t(main_data_t)) u_main_slot(
        .clk       ( clk           ),
        .rst       ( rst           ),
        .cs        ( main_rom_cs   ),
        .addr      ( main_rom_addr ),
        .offset    ( '0            ),
        .flush     ( dwnld_busy    ),
        .done      ( done[0]       ),
        .data_read ( data_read     ),
        .ok        ( main_rom_ok   ),
        .data      ( main_rom_data ),
        .req       ( req[0]        ),
        .req_addr  ( req_addr[0]   )
    );

    rom_slot #(.addr_t(gfx_addr_t), .data_t(gfx_data_t)) u_gfx_slot(
        .clk       ( clk          ),
        .rst       ( rst          ),
        .cs        ( gfx_rom_cs   ),
        .addr      ( gfx_rom_addr ),
        .offset    ( gfx_offset   ),
        .flush     ( dwnld_busy   ),
        .done      ( done[1]      ),
        .data_read ( data_read    ),
        .ok        ( gfx_rom_ok   ),
        .data      ( gfx_rom_data ),
        .req       ( req[1]       ),
        .req_addr  ( req_addr[1]  )
    );

    bank_arbiter u_arbiter(
        .clk      ( clk        ),
        .rst      ( rst        ),
        .req      ( req        ),
        .req_addr ( req_addr   ),
        .ba_ack   ( ba_ack     ),
        .ba_rdy   ( ba_rdy     ),
        .busy     ( dwnld_busy ),
        .done     ( done       ),
        .ba_addr  ( ba_addr    ),
        .ba_rd    ( ba_rd      )
    );

endmodule

`default_nettype wire

/* bench/rom_game_assertions.sv */
//////////////////////////////
// ROM game protocol checks
// Bank read and prog handshakes
//////////////////////////////

`default_nettype none

module rom_game_assertions import rom_pkg::*; (
    input logic              clk,
    input logic              rst,
    input logic              dwnld_busy,
    input logic              ba_rd,
    input logic              ba_ack,
    input logic [ADDR_W-1:0] ba_addr,
    input logic              prog_we,
    input logic              prog_rdy,
    input logic [ADDR_W-1:0] prog_addr,
    input logic [15:0]       prog_data
);

    int fail_count = 0;

    // Bank stays free during a download
    no_read_in_download: assert property (@(posedge clk) disable iff (rst)
        ba_rd |-> !dwnld_busy)
        else begin
            fail_count++;
            $error("bank read issued while download busy");
        end

    read_held: assert property (@(posedge clk) disable iff (rst)
        ba_rd && !ba_ack |=> ba_rd && $stable(ba_addr))
        else begin
            fail_count++;
            $error("ba_rd or ba_addr changed before ba_ack");
        end

    // Write word must not move until confirmed
    prog_held: assert property (@(posedge clk) disable iff (rst)
        prog_we && !prog_rdy |=> prog_we && $stable(prog_addr) && $stable(prog_data))
        else begin
            fail_count++;
            $error("prog_we dropped or prog word changed before prog_rdy");
        end

endmodule

bind rom_game rom_game_assertions u_assertions (
    .clk        ( clk        ),
    .rst        ( rst        ),
    .dwnld_busy ( dwnld_busy ),
    .ba_rd      ( ba_rd      ),
    .ba_ack     ( ba_ack     ),
    .ba_addr    ( ba_addr    ),
    .prog_we    ( prog_we    ),
    .prog_rdy   ( prog_rdy   ),
    .prog_addr  ( prog_addr  ),
    .prog_data  ( prog_data  )
);

`default_nettype wire

/* bench/tb_rom_game.sv */
//////////////////////////////
// ROM game testbench
// SDRAM model, random download and
// random ROM fetches on both clients
//////////////////////////////

`default_nettype none

module tb_rom_game import rom_pkg::*; ();

    localparam logic [31:0] SEED = 32'h9491_3bb9;
    localparam int MEM_WORDS = 65536;
    localparam int ROM_WORDS = 512;
    localparam int N_BYTES   = HEADER_LEN + 2 * ROM_WORDS;
    localparam int N_SOLO    = 24;
    localparam int N_PAIR    = 16;
    localparam int N_FETCH   = 4 * N_SOLO + 2 * N_PAIR;
    // Per byte the prog handshake and the gap
    // Per fetch two shared misses
    localparam int LIMIT     = 200 + N_BYTES * 12 + N_FETCH * 30;

    logic              clk;
    logic              rst;
    logic [24:0]       ioctl_addr;
    logic [7:0]        ioctl_data;
    logic              ioctl_wr;
    logic              downloading;
    logic              dwnld_busy;
    logic [ADDR_W-1:0] prog_addr;
    logic [15:0]       prog_data;
    logic [1:0]        prog_mask;
    logic              prog_we;
    logic              prog_rdy;
    logic [ADDR_W-1:0] ba_addr;
    logic              ba_rd;
    logic              ba_ack;
    logic              ba_rdy;
    logic [31:0]       data_read;
    logic              main_rom_cs;
    main_addr_t        main_rom_addr;
    logic              main_rom_ok;
    main_data_t        main_rom_data;
    logic              gfx_rom_cs;
    gfx_addr_t         gfx_rom_addr;
    logic              gfx_rom_ok;
    gfx_data_t         gfx_rom_data;

    logic [15:0]        sdram [MEM_WORDS];
    logic [15:0]        ref_mem [MEM_WORDS];
    logic [ADDR_W+15:0] exp_prog [$];
    logic [15:0]        gfx_base;
    logic [31:0]        stim_lfsr = SEED;
    logic [31:0]        rd_lfsr = SEED;
    logic [31:0]        pg_lfsr = SEED;
    int                 data_errs = 0;
    int                 proto_errs = 0;
    int                 cycles = 0;

    // Port names match the testbench signals
    rom_game i_rom_game (.*);

    initial clk = 1'b0;
    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= LIMIT) begin
            $display("Run stopped at the cycle limit of %0d before all tests ended", LIMIT);
            $display("Verification failed");
            $finish;
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // One LFSR step per bit taken
    task automatic rand_bits(inout logic [31:0] state, input int n, output int val);
        val = 0;
        for (int i = 0; i < n; i++) begin
            val = (val << 1) | int'(state[0]);
            state = lfsr_step(state);
        end
    endtask

    function automatic logic [15:0] fill_word(input int a);
        fill_word = 16'(a) ^ 16'(a << 7) ^ 16'hc3a5;
    endfunction

    task automatic check_main(input string name, input main_data_t got, input main_data_t exp);
        if (got !== exp) begin
            data_errs++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_gfx(input string name, input gfx_data_t got, input gfx_data_t exp);
        if (got !== exp) begin
            data_errs++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        if (got !== exp) begin
            data_errs++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_addr(input string name, input logic [ADDR_W-1:0] got,
                              input logic [ADDR_W-1:0] exp);
        if (got !== exp) begin
            data_errs++;
            $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_mask(input string name, input logic [1:0] got,
                              input logic [1:0] exp);
        if (got !== exp) begin
            data_errs++;
            $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    // SDRAM read port: ack, then data after 1 to 4 cycles
    initial begin : sdram_reads
        logic [ADDR_W-1:0] a;
        int d;
        ba_ack    = 1'b0;
        ba_rdy    = 1'b0;
        data_read = '0;
        forever begin
            @(negedge clk);
            if (ba_rd && !rst) begin
                a = ba_addr;
                ba_ack = 1'b1;
                @(negedge clk);
                ba_ack = 1'b0;
                rand_bits(rd_lfsr, 2, d);
                repeat (d) @(negedge clk);
                ba_rdy    = 1'b1;
                data_read = {sdram[16'(a + 1)], sdram[16'(a)]};
                @(negedge clk);
                ba_rdy = 1'b0;
            end
        end
    end

    // SDRAM programming port
    initial begin : sdram_prog
        logic [ADDR_W+15:0] e;
        int d;
        prog_rdy = 1'b0;
        forever begin
            @(negedge clk);
            if (prog_we && !rst) begin
                if (exp_prog.size() == 0) begin
                    proto_errs++;
                    $display("%0t: prog write with no downloaded byte pair behind it", $time);
                end else begin
                    e = exp_prog.pop_front();
                    check_addr("prog_addr", prog_addr, e[ADDR_W+15:16]);
                    check_word("prog_data", prog_data, e[15:0]);
                end
                // Both bytes are written on every prog word
                check_mask("prog_mask", prog_mask, 2'b00);
                sdram[16'(prog_addr)] = prog_data;
                rand_bits(pg_lfsr, 2, d);
                repeat (d) @(negedge clk);
                prog_rdy = 1'b1;
                @(negedge clk);
                prog_rdy = 1'b0;
            end
        end
    end

    task automatic download();
        int b;
        int k;
        int gap;
        logic [7:0] byte_v;
        logic [7:0] low_v;
        downloading = 1'b1;
        for (int i = 0; i < N_BYTES; i++) begin
            rand_bits(stim_lfsr, 8, b);
            byte_v = (i < HEADER_LEN) ? gfx_base[8*i +: 8] : 8'(b);
            k = i - HEADER_LEN;
            if (k >= 0 && k % 2 == 0) begin
                low_v = byte_v;
            end else if (k >= 0) begin
                exp_prog.push_back({ADDR_W'(k / 2), byte_v, low_v});
                ref_mem[k / 2] = {byte_v, low_v};
            end
            ioctl_addr = 25'(i);
            ioctl_data = byte_v;
            ioctl_wr   = 1'b1;
            @(negedge clk);
            ioctl_wr = 1'b0;
            // Next word only once the previous one is written
            while (prog_we) @(negedge clk);
            rand_bits(stim_lfsr, 2, gap);
            repeat (gap) @(negedge clk);
        end
        downloading = 1'b0;
        while (dwnld_busy) @(negedge clk);
    endtask

    task automatic fetch_main(input main_addr_t a, input logic cached);
        main_rom_addr = a;
        main_rom_cs   = 1'b1;
        @(negedge clk);
        if (cached && (main_rom_ok !== 1'b1 || ba_rd !== 1'b0)) begin
            proto_errs++;
            $display("%0t: cached main fetch at %h was not answered in one cycle", $time, a);
        end
        while (main_rom_ok !== 1'b1) @(negedge clk);
        check_main("main_rom_data", main_rom_data, ref_mem[16'(a)]);
        main_rom_cs = 1'b0;
        @(negedge clk);
    endtask

    task automatic fetch_gfx(input gfx_addr_t a, input logic cached);
        int w;
        w = int'(gfx_base) * 64 + int'(a);
        gfx_rom_addr = a;
        gfx_rom_cs   = 1'b1;
        @(negedge clk);
        if (cached && (gfx_rom_ok !== 1'b1 || ba_rd !== 1'b0)) begin
            proto_errs++;
            $display("%0t: cached graphics fetch at %h was not answered in one cycle", $time, a);
        end
        while (gfx_rom_ok !== 1'b1) @(negedge clk);
        check_gfx("gfx_rom_data", gfx_rom_data, {ref_mem[16'(w + 1)], ref_mem[16'(w)]});
        gfx_rom_cs = 1'b0;
        @(negedge clk);
    endtask

    initial begin : stimulus
        int v;
        int fails;
        main_addr_t ma;
        gfx_addr_t ga;
        rst           = 1'b1;
        ioctl_addr    = '0;
        ioctl_data    = '0;
        ioctl_wr      = 1'b0;
        downloading   = 1'b0;
        main_rom_cs   = 1'b0;
        main_rom_addr = '0;
        gfx_rom_cs    = 1'b0;
        gfx_rom_addr  = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            sdram[i]   = fill_word(i);
            ref_mem[i] = fill_word(i);
        end
        repeat (5) @(negedge clk);
        rst = 1'b0;
        if (ba_rd || prog_we || main_rom_ok || gfx_rom_ok) begin
            proto_errs++;
            $display("%0t: outputs not low after reset", $time);
        end

        // Region start with a nonzero high header byte
        rand_bits(stim_lfsr, 8, v);
        gfx_base = 16'h0100 + 16'(v);
        download();
        if (exp_prog.size() != 0) begin
            proto_errs++;
            $display("%0t: %0d prog writes never arrived", $time, exp_prog.size());
        end

        // Miss then a repeat of the same address
        for (int i = 0; i < N_SOLO; i++) begin
            rand_bits(stim_lfsr, 9, v);
            ma = main_addr_t'(v);
            fetch_main(ma, 1'b0);
            fetch_main(ma, 1'b1);
            rand_bits(stim_lfsr, 8, v);
            ga = gfx_addr_t'(v);
            fetch_gfx(ga, 1'b0);
            fetch_gfx(ga, 1'b1);
        end

        // Both clients at once
        for (int i = 0; i < N_PAIR; i++) begin
            rand_bits(stim_lfsr, 9, v);
            ma = main_addr_t'(v);
            rand_bits(stim_lfsr, 8, v);
            ga = gfx_addr_t'(v);
            fork
                fetch_main(ma, 1'b0);
                fetch_gfx(ga, 1'b0);
            join
        end

        repeat (4) @(negedge clk);
        fails = i_rom_game.u_assertions.fail_count;
        $display("Errors: %0d data, %0d protocol, %0d assertion", data_errs, proto_errs, fails);
        if (data_errs + proto_errs + fails == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* rom_game.f */
rtl/rom_pkg.sv
rtl/rom_loader.sv
rtl/region_cfg.sv
rtl/rom_slot.sv
rtl/bank_arbiter.sv
rtl/rom_game.sv
bench/rom_game_assertions.sv
bench/tb_rom_game.sv

/* Bender.yml */
package:
  name: rom_game

sources:
  - rtl/rom_pkg.sv
  - rtl/rom_loader.sv
  - rtl/region_cfg.sv
  - rtl/rom_slot.sv
  - rtl/bank_arbiter.sv
  - rtl/rom_game.sv
  - target: simulation
    files:
      - bench/rom_game_assertions.sv
      - bench/tb_rom_game.sv
